// ==== can_tx_node.f ====
can_pkg.sv
can_tx_mailbox.sv
can_tx_arbiter.sv
can_frame_tx.sv
can_tx_node.sv
tb_can_tx_node_asserts.sv
tb_can_tx_node.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CAN transmit node testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_can_tx_node \
    -f can_tx_node.f \
    -o sim_can_tx_node

./obj_dir/sim_can_tx_node

// ==== tb_can_tx_node.sv ====
`timescale 1ns/1ps

module tb_can_tx_node;

    localparam int FRAME_MAX = 160;
    localparam int MAX_FRAME_BITS = 135;
    localparam int NUM_FRAMES = 14;
    localparam int TIMEOUT_CYCLES = 40 * MAX_FRAME_BITS * NUM_FRAMES;

    // Bit i of a frame vector is the i-th bit on the line
    typedef logic [FRAME_MAX-1:0] frame_bits_t;

    logic clk;
    logic rst_n;
    logic wr_en;
    can_pkg::mbox_idx_t wr_sel;
    can_pkg::can_msg_t wr_msg;
    logic tx;
    logic busy;
    logic [can_pkg::NUM_MBOX-1:0] pending;
    logic tx_done;
    can_pkg::mbox_idx_t mbox_done;

    string exp_name [$];
    can_pkg::can_msg_t exp_msg [$];
    can_pkg::mbox_idx_t exp_idx [$];
    int frames_queued;
    int frames_checked;
    int cycles;

    can_tx_node u_can_tx_node (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wr_msg    (wr_msg),
        .tx        (tx),
        .busy      (busy),
        .pending   (pending),
        .tx_done   (tx_done),
        .mbox_done (mbox_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d frames checked",
                     cycles, frames_checked, frames_queued);
            $display("Test failures found");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    // ##################################################
    // Reference frame and compare tasks

    function automatic void expected_frame(input can_pkg::can_msg_t m,
                                           output frame_bits_t bits, output int len);
        logic raw [$];
        can_pkg::crc15_t crc;
        int nbytes;
        int run;
        logic last;
        logic fb;
        bits = '0;
        len = 0;
        crc = '0;
        nbytes = (m.dlc > 8) ? 8 : int'(m.dlc);
        // SOF, identifier, RTR, IDE, r0, DLC and data
        raw.push_back(1'b0);
        for (int i = 10; i >= 0; i--) raw.push_back(m.id[i]);
        repeat (3) raw.push_back(1'b0);
        for (int i = 3; i >= 0; i--) raw.push_back(m.dlc[i]);
        for (int i = 0; i < nbytes * 8; i++) raw.push_back(m.data[63 - i]);
        foreach (raw[i]) begin
            fb = raw[i] ^ crc[14];
            crc = {crc[13:0], 1'b0};
            if (fb) crc = crc ^ can_pkg::CRC15_POLY;
        end
        for (int i = 14; i >= 0; i--) raw.push_back(crc[i]);
        run = 0;
        last = 1'b1;
        foreach (raw[i]) begin
            bits[len] = raw[i];
            len++;
            if (raw[i] == last) begin
                run++;
            end else begin
                run = 1;
                last = raw[i];
            end
            if (run == 5) begin
                bits[len] = ~last;
                len++;
                last = ~last;
                run = 1;
            end
        end
        // CRC delimiter, ACK slot, ACK delimiter and EOF plus intermission
        repeat (13) begin
            bits[len] = 1'b1;
            len++;
        end
    endfunction

    task automatic check_frame(input string name, input frame_bits_t exp_bits,
                               input int exp_len, input frame_bits_t act_bits, input int act_len);
        if (exp_len != act_len || exp_bits !== act_bits) begin
            stop_run($sformatf("mismatch %s: expected %0d bits %h, actual %0d bits %h",
                               name, exp_len, exp_bits, act_len, act_bits));
        end
    endtask

    task automatic check_idx(input string name, input can_pkg::mbox_idx_t exp_val,
                             input can_pkg::mbox_idx_t act_val);
        if (exp_val !== act_val) begin
            stop_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp_val, act_val));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (exp_val !== act_val) begin
            stop_run($sformatf("mismatch %s: expected %b, actual %b", name, exp_val, act_val));
        end
    endtask

    // ##################################################
    // Bit capture and compare

    initial begin : monitor
        frame_bits_t cap;
        frame_bits_t exp_bits;
        int len;
        int exp_len;
        int cnt;
        logic in_frame;
        forever begin
            @(negedge clk);
            if (rst_n && busy && !tx) begin
                cap = '0;
                len = 0;
                cnt = 0;
                in_frame = 1'b1;
                while (in_frame) begin
                    @(negedge clk);
                    cnt++;
                    if (tx_done) begin
                        in_frame = 1'b0;
                    end else if (len >= FRAME_MAX) begin
                        stop_run("captured frame is longer than any valid frame");
                    end else if (cnt % can_pkg::BIT_CLKS == can_pkg::BIT_CLKS / 2) begin
                        cap[len] = tx;
                        len++;
                    end
                end
                if (exp_msg.size() == 0) begin
                    stop_run("a frame was sent while no frame was expected");
                end else begin
                    expected_frame(exp_msg[0], exp_bits, exp_len);
                    check_frame(exp_name[0], exp_bits, exp_len, cap, len);
                    check_idx($sformatf("%s index", exp_name[0]), exp_idx[0], mbox_done);
                    void'(exp_name.pop_front());
                    void'(exp_msg.pop_front());
                    void'(exp_idx.pop_front());
                    frames_checked++;
                end
            end
        end
    end

    // ##################################################
    // Stimulus

    function automatic can_pkg::can_msg_t random_msg(input can_pkg::can_dlc_t dlc);
        can_pkg::can_msg_t m;
        m.id = can_pkg::can_id_t'($urandom);
        m.dlc = dlc;
        m.data = {$urandom, $urandom};
        return m;
    endfunction

    task automatic write_mbox(input can_pkg::mbox_idx_t sel, input can_pkg::can_msg_t m);
        @(posedge clk);
        wr_en <= 1'b1;
        wr_sel <= sel;
        wr_msg <= m;
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic queue_frame(input string name, input can_pkg::mbox_idx_t idx,
                               input can_pkg::can_msg_t m);
        exp_name.push_back(name);
        exp_idx.push_back(idx);
        exp_msg.push_back(m);
        frames_queued++;
    endtask

    task automatic send_and_wait(input string name, input can_pkg::mbox_idx_t sel,
                                 input can_pkg::can_msg_t m);
        queue_frame(name, sel, m);
        write_mbox(sel, m);
        wait (frames_checked == frames_queued);
    endtask

    initial begin
        can_pkg::can_msg_t m;
        can_pkg::can_msg_t lo;
        can_pkg::can_msg_t hi;
        can_pkg::can_msg_t late;
        void'($urandom(32'hb2e9));
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_sel = '0;
        wr_msg = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_flag("reset tx", 1'b1, tx);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset pending", 1'b0, |pending);
        repeat (20 * can_pkg::BIT_CLKS) begin
            @(negedge clk);
            check_flag("idle tx_done", 1'b0, tx_done);
        end

        m = random_msg(can_pkg::can_dlc_t'($urandom_range(8, 0)));
        send_and_wait("single frame", '0, m);
        @(negedge clk);
        check_flag("single frame pending", 1'b0, pending[0]);

        // Long runs of equal bits and alternating patterns
        send_and_wait("stuff zeros", '0, '{id: 11'h000, dlc: 4'd8, data: '0});
        send_and_wait("stuff ones", '0, '{id: 11'h7ff, dlc: 4'd8, data: '1});
        send_and_wait("stuff alt a", '0, '{id: 11'h555, dlc: 4'd8, data: 64'haaaa_aaaa_aaaa_aaaa});
        send_and_wait("stuff alt 5", '0, '{id: 11'h2aa, dlc: 4'd8, data: 64'h5555_5555_5555_5555});

        // A second write cannot land before the first is granted, so the
        // lower identifier goes in first
        for (int k = 0; k < 2; k++) begin
            lo = random_msg(4'd8);
            hi = random_msg(4'd8);
            lo.id = {1'b0, lo.id[9:0]};
            hi.id = {1'b1, hi.id[9:0]};
            queue_frame("priority low id", can_pkg::mbox_idx_t'(k), lo);
            queue_frame("priority high id", can_pkg::mbox_idx_t'(1 - k), hi);
            write_mbox(can_pkg::mbox_idx_t'(k), lo);
            write_mbox(can_pkg::mbox_idx_t'(1 - k), hi);
            wait (frames_checked == frames_queued);
        end

        for (int k = 0; k < 3; k++) begin
            m = random_msg(can_pkg::can_dlc_t'($urandom_range(15, 9)));
            send_and_wait("dlc over 8", can_pkg::mbox_idx_t'(k % 2), m);
        end

        m = random_msg(can_pkg::can_dlc_t'($urandom_range(8, 0)));
        lo = random_msg(can_pkg::can_dlc_t'($urandom_range(8, 0)));
        late = random_msg(can_pkg::can_dlc_t'($urandom_range(8, 0)));
        queue_frame("write during own send", '0, m);
        queue_frame("write to other mailbox", 1'b1, late);
        write_mbox('0, m);
        while (!busy) @(negedge clk);
        write_mbox('0, lo);
        write_mbox(1'b1, late);
        wait (frames_checked == frames_queued);
        @(negedge clk);
        check_flag("dropped write pending", 1'b0, |pending);

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== tb_can_tx_node_asserts.sv ====
`timescale 1ns/1ps

module tb_can_tx_node_asserts (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic tx,
    input logic busy,
    input logic done
);

    // The line stays recessive between frames
    idle_recessive: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx)
        else $error("tx is dominant while the transmitter is idle");

    done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stays high for more than one cycle");

    done_idle: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
        else $error("busy is still high when done pulses");

    start_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else $error("start arrives while a frame is in flight");

endmodule

bind can_frame_tx tb_can_tx_node_asserts u_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .tx    (tx),
    .busy  (busy),
    .done  (done)
);

// ==== can_tx_node.sv ====
`timescale 1ns/1ps

module can_tx_node (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  can_pkg::mbox_idx_t            wr_sel,
    input  can_pkg::can_msg_t             wr_msg,
    output logic                          tx,
    output logic                          busy,
    output logic [can_pkg::NUM_MBOX-1:0]  pending,
    output logic                          tx_done,
    output can_pkg::mbox_idx_t            mbox_done
);

    logic [can_pkg::NUM_MBOX-1:0] load;
    logic [can_pkg::NUM_MBOX-1:0] clear;
    can_pkg::can_msg_t mbox_msg [can_pkg::NUM_MBOX];
    can_pkg::can_msg_t frame_msg;
    logic start;

    // ##################################################
    // Transmit mailboxes

    for (genvar i = 0; i < can_pkg::NUM_MBOX; i++) begin : g_mbox
        assign load[i] = wr_en && (wr_sel == can_pkg::mbox_idx_t'(i));

        can_tx_mailbox u_mbox (
            .clk      (clk),
            .rst_n    (rst_n),
            .load     (load[i]),
            .load_msg (wr_msg),
            .clear    (clear[i]),
            .pending  (pending[i]),
            .msg      (mbox_msg[i])
        );
    end

    can_tx_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (pending),
        .msgs      (mbox_msg),
        .busy      (busy),
        .done      (tx_done),
        .start     (start),
        .frame_msg (frame_msg),
        .clear     (clear),
        .mbox_done (mbox_done)
    );

    can_frame_tx u_frame_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .msg   (frame_msg),
        .tx    (tx),
        .busy  (busy),
        .done  (tx_done)
    );

endmodule

// ==== can_frame_tx.sv ====
`timescale 1ns/1ps

module can_frame_tx (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  can_pkg::can_msg_t msg,
    output logic              tx,
    output logic              busy,
    output logic              done
);

    can_pkg::tx_state_t state;
    can_pkg::tick_cnt_t tick_cnt;
    can_pkg::frame_cnt_t bit_cnt;
    can_pkg::frame_cnt_t data_end;
    can_pkg::frame_cnt_t frame_end;
    can_pkg::crc15_t crc;
    logic [can_pkg::SREG_BITS-1:0] sreg;
    logic [4:0] history;
    logic tick;
    logic stuff_now;
    logic in_data;
    logic next_bit;

    function automatic can_pkg::crc15_t crc15_step(input can_pkg::crc15_t c, input logic b);
        logic fb;
        fb = c[14] ^ b;
        crc15_step = {c[13:0], 1'b0} ^ (fb ? can_pkg::CRC15_POLY : '0);
    endfunction

    // Number of frame bits after SOF up to the end of the data field
    function automatic can_pkg::frame_cnt_t data_field_end(input can_pkg::can_dlc_t dlc);
        can_pkg::frame_cnt_t nbytes;
        if (dlc > can_pkg::can_dlc_t'(can_pkg::MAX_DATA_BYTES)) begin
            nbytes = can_pkg::frame_cnt_t'(can_pkg::MAX_DATA_BYTES);
        end else begin
            nbytes = can_pkg::frame_cnt_t'(dlc);
        end
        data_field_end = can_pkg::frame_cnt_t'(can_pkg::HDR_BITS) + (nbytes << 3);
    endfunction

    assign tick = busy && (tick_cnt == '0);
    assign in_data = bit_cnt < data_end;
    assign frame_end = data_end + can_pkg::frame_cnt_t'(can_pkg::CRC_BITS);
    assign next_bit = in_data ? sreg[can_pkg::SREG_BITS-1] : crc[14];

    // Five equal bits on the line call for a bit of the other value
    assign stuff_now = (history == 5'b00000) || (history == 5'b11111);

    // ##################################################
    // Header and data shift register

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            // RTR, IDE and r0 are all dominant for a base data frame
            sreg <= {msg.id, 3'b000, msg.dlc, msg.data};
            data_end <= data_field_end(msg.dlc);
        end else if (tick && state == can_pkg::st_send && !stuff_now && in_data) begin
            sreg <= {sreg[can_pkg::SREG_BITS-2:0], 1'b0};
        end
    end

    // ##################################################
    // Bit timing and frame sequencing

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= can_pkg::st_idle;
            tick_cnt <= '0;
            bit_cnt <= '0;
            crc <= '0;
            history <= '0;
            tx <= 1'b1;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                // First tick lands on the next cycle and sends SOF
                busy <= 1'b1;
                state <= can_pkg::st_sof;
                tick_cnt <= '0;
                crc <= '0;
            end else if (busy && tick_cnt != '0) begin
                tick_cnt <= tick_cnt - 1'b1;
            end else if (tick) begin
                tick_cnt <= can_pkg::tick_cnt_t'(can_pkg::BIT_CLKS - 1);
                case (state)
                    can_pkg::st_sof: begin
                        tx <= 1'b0;
                        crc <= crc15_step(crc, 1'b0);
                        // Only the SOF bit counts toward the first run
                        history <= 5'b01010;
                        bit_cnt <= '0;
                        state <= can_pkg::st_send;
                    end
                    can_pkg::st_send: begin
                        if (stuff_now) begin
                            tx <= ~history[0];
                            history <= {history[3:0], ~history[0]};
                        end else if (bit_cnt == frame_end) begin
                            // CRC delimiter
                            tx <= 1'b1;
                            bit_cnt <= '0;
                            state <= can_pkg::st_ack;
                        end else begin
                            tx <= next_bit;
                            history <= {history[3:0], next_bit};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (in_data) begin
                                crc <= crc15_step(crc, next_bit);
                            end else begin
                                crc <= {crc[13:0], 1'b0};
                            end
                        end
                    end
                    can_pkg::st_ack: begin
                        // ACK slot and ACK delimiter are both left recessive
                        tx <= 1'b1;
                        if (bit_cnt == can_pkg::frame_cnt_t'(1)) begin
                            bit_cnt <= '0;
                            state <= can_pkg::st_eof;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    can_pkg::st_eof: begin
                        if (bit_cnt == can_pkg::frame_cnt_t'(can_pkg::EOF_BITS)) begin
                            busy <= 1'b0;
                            done <= 1'b1;
                            state <= can_pkg::st_idle;
                        end else begin
                            tx <= 1'b1;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: begin
                        tx <= 1'b1;
                        busy <= 1'b0;
                        state <= can_pkg::st_idle;
                    end
                endcase
            end
        end
    end

endmodule

// ==== can_tx_arbiter.sv ====
`timescale 1ns/1ps

module can_tx_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [can_pkg::NUM_MBOX-1:0]  req,
    input  can_pkg::can_msg_t             msgs [can_pkg::NUM_MBOX],
    input  logic                          busy,
    input  logic                          done,
    output logic                          start,
    output can_pkg::can_msg_t             frame_msg,
    output logic [can_pkg::NUM_MBOX-1:0]  clear,
    output can_pkg::mbox_idx_t            mbox_done
);

    logic [can_pkg::NUM_MBOX-1:0] eligible;
    can_pkg::mbox_idx_t win_idx;
    can_pkg::mbox_idx_t granted;
    logic win_ok;
    logic outstanding;
    logic grant;

    // The finished mailbox is released in the same cycle as done
    always_comb begin
        clear = '0;
        if (done) begin
            clear[granted] = 1'b1;
        end
    end

    // A mailbox being cleared must not win again on stale pending
    assign eligible = req & ~clear;

    // ##################################################
    // Lowest identifier wins, ties go to the lower index

    always_comb begin
        win_idx = '0;
        win_ok = 1'b0;
        for (int i = 0; i < can_pkg::NUM_MBOX; i++) begin
            if (eligible[i] && (!win_ok || msgs[i].id < msgs[win_idx].id)) begin
                win_idx = can_pkg::mbox_idx_t'(i);
                win_ok = 1'b1;
            end
        end
    end

    assign grant = win_ok && !busy && !outstanding;

    // Outstanding covers the cycle between the start pulse and busy rising
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start <= 1'b0;
            outstanding <= 1'b0;
            granted <= '0;
        end else begin
            start <= grant;
            if (grant) begin
                outstanding <= 1'b1;
                granted <= win_idx;
            end else if (busy) begin
                outstanding <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            frame_msg <= msgs[win_idx];
        end
    end

    assign mbox_done = granted;

endmodule

// ==== can_tx_mailbox.sv ====
`timescale 1ns/1ps

module can_tx_mailbox (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load,
    input  can_pkg::can_msg_t load_msg,
    input  logic              clear,
    output logic              pending,
    output can_pkg::can_msg_t msg
);

    logic accept;

    // A full mailbox ignores further writes until its frame has gone out
    assign accept = load && !pending;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (clear) begin
            pending <= 1'b0;
        end
    end

    // The message is held until the next accepted load, so the
    // arbiter can compare identifiers at any time
    always_ff @(posedge clk) begin
        if (accept) begin
            msg <= load_msg;
        end
    end

endmodule

// ==== can_pkg.sv ====
package can_pkg;

    // ##################################################
    // Sizes and bit timing

    localparam int NUM_MBOX = 2;
    localparam int MAX_DATA_BYTES = 8;
    localparam int DATA_BITS = MAX_DATA_BYTES * 8;

    // Clock cycles in one CAN bit
    localparam int BIT_CLKS = 4;

    // Seven end-of-frame bits followed by three intermission bits
    localparam int EOF_BITS = 10;

    // Identifier, RTR, IDE, r0 and DLC as sent after SOF
    localparam int HDR_BITS = 18;
    localparam int CRC_BITS = 15;
    localparam int SREG_BITS = HDR_BITS + DATA_BITS;
    localparam int TICK_W = $clog2(BIT_CLKS) + 1;

    // ##################################################
    // Types

    typedef logic [10:0] can_id_t;
    typedef logic [3:0] can_dlc_t;
    typedef logic [DATA_BITS-1:0] can_data_t;
    typedef logic [CRC_BITS-1:0] crc15_t;
    typedef logic [$clog2(NUM_MBOX)-1:0] mbox_idx_t;
    typedef logic [6:0] frame_cnt_t;
    typedef logic [TICK_W-1:0] tick_cnt_t;

    localparam crc15_t CRC15_POLY = 15'h4599;

    // Byte 0 of the payload sits in the top byte and goes out first
    typedef struct packed {
        can_id_t   id;
        can_dlc_t  dlc;
        can_data_t data;
    } can_msg_t;

    typedef enum logic [2:0] {
        st_idle,
        st_sof,
        st_send,
        st_ack,
        st_eof
    } tx_state_t;

endpackage
